//--- soc_bus_pkg.sv
package soc_bus_pkg;

    // Bus geometry. Every address selects one full data word.
    parameter int DATA_WIDTH = 32;
    parameter int ADDR_WIDTH = 32;

    // Number of GPIO pins on device 1.
    parameter int GPIO_WIDTH = 8;

    // Default address map, with inclusive word address ranges.
    parameter logic [ADDR_WIDTH-1:0] DEVICE0_START = 32'h0000_0000;
    parameter logic [ADDR_WIDTH-1:0] DEVICE0_FINAL = 32'h0000_0FFF;

    parameter logic [ADDR_WIDTH-1:0] DEVICE1_START = 32'h0000_1000;
    parameter logic [ADDR_WIDTH-1:0] DEVICE1_FINAL = 32'h0000_1002;

    // The buffer memory spans 770 words.
    parameter logic [ADDR_WIDTH-1:0] DEVICE2_START = 32'h0000_10B9;
    parameter logic [ADDR_WIDTH-1:0] DEVICE2_FINAL = 32'h0000_13BA;

    parameter logic [ADDR_WIDTH-1:0] DEVICE3_START = 32'h0000_13BB;
    parameter logic [ADDR_WIDTH-1:0] DEVICE3_FINAL = 32'h0000_13BE;

endpackage

//--- bus_port_if.sv
`timescale 1ns/10ps

interface bus_port_if;

    logic                              read;
    logic                              write;
    logic [soc_bus_pkg::ADDR_WIDTH-1:0] address;
    logic [soc_bus_pkg::DATA_WIDTH-1:0] write_data;
    logic [soc_bus_pkg::DATA_WIDTH-1:0] read_data;

    // The decoder drives the request side of the port.
    modport master (output read, output write, output address, output write_data,
                    input read_data);

    // A device answers with read data in the same cycle.
    modport slave (input read, input write, input address, input write_data,
                   output read_data);

endinterface

//--- bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder #(
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] DEVICE0_START = soc_bus_pkg::DEVICE0_START,
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] DEVICE0_FINAL = soc_bus_pkg::DEVICE0_FINAL,
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] DEVICE1_START = soc_bus_pkg::DEVICE1_START,
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] DEVICE1_FINAL = soc_bus_pkg::DEVICE1_FINAL,
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] DEVICE2_START = soc_bus_pkg::DEVICE2_START,
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] DEVICE2_FINAL = soc_bus_pkg::DEVICE2_FINAL,
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] DEVICE3_START = soc_bus_pkg::DEVICE3_START,
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] DEVICE3_FINAL = soc_bus_pkg::DEVICE3_FINAL
) (
    input  logic                               read,
    input  logic                               write,
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0] address,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0] write_data,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0] read_data,
    bus_port_if.master                         dev0,
    bus_port_if.master                         dev1,
    bus_port_if.master                         dev2,
    bus_port_if.master                         dev3
);

    logic [3:0] hit;

    // One inclusive range compare per device. The ranges must not overlap.
    assign hit[0] = (address >= DEVICE0_START) && (address <= DEVICE0_FINAL);
    assign hit[1] = (address >= DEVICE1_START) && (address <= DEVICE1_FINAL);
    assign hit[2] = (address >= DEVICE2_START) && (address <= DEVICE2_FINAL);
    assign hit[3] = (address >= DEVICE3_START) && (address <= DEVICE3_FINAL);

    // A port that is not addressed sees idle strobes and zero payload.
    assign dev0.read       = hit[0] & read;
    assign dev0.write      = hit[0] & write;
    assign dev0.address    = hit[0] ? address : '0;
    assign dev0.write_data = hit[0] ? write_data : '0;

    assign dev1.read       = hit[1] & read;
    assign dev1.write      = hit[1] & write;
    assign dev1.address    = hit[1] ? address : '0;
    assign dev1.write_data = hit[1] ? write_data : '0;

    assign dev2.read       = hit[2] & read;
    assign dev2.write      = hit[2] & write;
    assign dev2.address    = hit[2] ? address : '0;
    assign dev2.write_data = hit[2] ? write_data : '0;

    assign dev3.read       = hit[3] & read;
    assign dev3.write      = hit[3] & write;
    assign dev3.address    = hit[3] ? address : '0;
    assign dev3.write_data = hit[3] ? write_data : '0;

    // Unmapped addresses read as zero.
    always_comb begin
        if (hit[0]) begin
            read_data = dev0.read_data;
        end else if (hit[1]) begin
            read_data = dev1.read_data;
        end else if (hit[2]) begin
            read_data = dev2.read_data;
        end else if (hit[3]) begin
            read_data = dev3.read_data;
        end else begin
            read_data = '0;
        end
    end

endmodule

//--- word_memory.sv
`timescale 1ns/10ps

module word_memory #(
    parameter int                               DEPTH = 4096,
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] BASE  = '0
) (
    input  logic       clk,
    input  logic       reset,
    bus_port_if.slave  bus
);

    localparam int INDEX_WIDTH = $clog2(DEPTH);

    logic [soc_bus_pkg::DATA_WIDTH-1:0] mem [DEPTH];
    logic [soc_bus_pkg::ADDR_WIDTH-1:0] offset;
    logic [INDEX_WIDTH-1:0]             index;

    // The decoder has already checked the range, so the offset is below DEPTH.
    assign offset = bus.address - BASE;
    assign index  = offset[INDEX_WIDTH-1:0];

    // Writes are held off while reset is asserted; the contents themselves survive.
    always_ff @(posedge clk) begin
        if (bus.write && !reset) begin
            mem[index] <= bus.write_data;
        end
    end

    assign bus.read_data = bus.read ? mem[index] : '0;

endmodule

//--- gpio_registers.sv
`timescale 1ns/10ps

module gpio_registers #(
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] BASE       = soc_bus_pkg::DEVICE1_START,
    parameter int                               GPIO_WIDTH = soc_bus_pkg::GPIO_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out,
    bus_port_if.slave             bus
);

    localparam int DW = soc_bus_pkg::DATA_WIDTH;

    logic [GPIO_WIDTH-1:0]              out_latch;
    logic [GPIO_WIDTH-1:0]              in_sample;
    logic [soc_bus_pkg::ADDR_WIDTH-1:0] offset;

    assign offset = bus.address - BASE;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_latch <= '0;
        end else if (bus.write) begin
            case (offset[1:0])
                2'd0:    out_latch <= bus.write_data[GPIO_WIDTH-1:0];
                2'd2:    out_latch <= out_latch ^ bus.write_data[GPIO_WIDTH-1:0];
                default: out_latch <= out_latch;
            endcase
        end
    end

    // One register stage on the pins, so a read shows the value from the last edge.
    always_ff @(posedge clk) begin
        in_sample <= gpio_in;
    end

    always_comb begin
        bus.read_data = '0;
        if (bus.read) begin
            case (offset[1:0])
                2'd0:    bus.read_data = {{(DW - GPIO_WIDTH){1'b0}}, out_latch};
                2'd1:    bus.read_data = {{(DW - GPIO_WIDTH){1'b0}}, in_sample};
                default: bus.read_data = '0;
            endcase
        end
    end

    assign gpio_out = out_latch;

endmodule

//--- interval_timer.sv
`timescale 1ns/10ps

module interval_timer #(
    parameter logic [soc_bus_pkg::ADDR_WIDTH-1:0] BASE = soc_bus_pkg::DEVICE3_START
) (
    input  logic      clk,
    input  logic      reset,
    output logic      irq,
    bus_port_if.slave bus
);

    localparam int DW = soc_bus_pkg::DATA_WIDTH;

    logic [DW-1:0]                      count;
    logic [DW-1:0]                      compare;
    logic [2:0]                         control;
    logic                               match;
    logic [soc_bus_pkg::ADDR_WIDTH-1:0] offset;

    assign offset = bus.address - BASE;

    // Control bits: 0 enable, 1 auto-reload, 2 interrupt enable.
    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            compare <= '0;
            control <= '0;
            match   <= 1'b0;
            irq     <= 1'b0;
        end else begin
            if (control[0]) begin
                if (count == compare) begin
                    match <= 1'b1;
                    count <= control[1] ? '0 : count + 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
            // A bus write in the same cycle overrides the counter update.
            if (bus.write) begin
                case (offset[1:0])
                    2'd0: count   <= bus.write_data;
                    2'd1: compare <= bus.write_data;
                    2'd2: control <= bus.write_data[2:0];
                    2'd3: begin
                        if (bus.write_data[0]) begin
                            match <= 1'b0;
                        end
                    end
                endcase
            end
            irq <= match & control[2];
        end
    end

    always_comb begin
        bus.read_data = '0;
        if (bus.read) begin
            case (offset[1:0])
                2'd0: bus.read_data = count;
                2'd1: bus.read_data = compare;
                2'd2: bus.read_data = {{(DW - 3){1'b0}}, control};
                2'd3: bus.read_data = {{(DW - 1){1'b0}}, match};
            endcase
        end
    end

endmodule

//--- soc_bus_top.sv
`timescale 1ns/10ps

module soc_bus_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                read,
    input  logic                                write,
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  address,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  write_data,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  read_data,
    input  logic [soc_bus_pkg::GPIO_WIDTH-1:0]  gpio_in,
    output logic [soc_bus_pkg::GPIO_WIDTH-1:0]  gpio_out,
    output logic                                timer_irq
);

    bus_port_if dev0 ();
    bus_port_if dev1 ();
    bus_port_if dev2 ();
    bus_port_if dev3 ();

    bus_decoder #(
        .DEVICE0_START (soc_bus_pkg::DEVICE0_START),
        .DEVICE0_FINAL (soc_bus_pkg::DEVICE0_FINAL),
        .DEVICE1_START (soc_bus_pkg::DEVICE1_START),
        .DEVICE1_FINAL (soc_bus_pkg::DEVICE1_FINAL),
        .DEVICE2_START (soc_bus_pkg::DEVICE2_START),
        .DEVICE2_FINAL (soc_bus_pkg::DEVICE2_FINAL),
        .DEVICE3_START (soc_bus_pkg::DEVICE3_START),
        .DEVICE3_FINAL (soc_bus_pkg::DEVICE3_FINAL)
    ) u_decoder (
        .read       (read),
        .write      (write),
        .address    (address),
        .write_data (write_data),
        .read_data  (read_data),
        .dev0       (dev0.master),
        .dev1       (dev1.master),
        .dev2       (dev2.master),
        .dev3       (dev3.master)
    );

    // Data memory.
    word_memory #(
        .DEPTH (4096),
        .BASE  (soc_bus_pkg::DEVICE0_START)
    ) u_data_mem (
        .clk   (clk),
        .reset (reset),
        .bus   (dev0.slave)
    );

    gpio_registers #(
        .BASE       (soc_bus_pkg::DEVICE1_START),
        .GPIO_WIDTH (soc_bus_pkg::GPIO_WIDTH)
    ) u_gpio (
        .clk      (clk),
        .reset    (reset),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .bus      (dev1.slave)
    );

    // Buffer memory.
    word_memory #(
        .DEPTH (770),
        .BASE  (soc_bus_pkg::DEVICE2_START)
    ) u_buffer_mem (
        .clk   (clk),
        .reset (reset),
        .bus   (dev2.slave)
    );

    interval_timer #(
        .BASE (soc_bus_pkg::DEVICE3_START)
    ) u_timer (
        .clk   (clk),
        .reset (reset),
        .irq   (timer_irq),
        .bus   (dev3.slave)
    );

endmodule

//--- soc_bus_assertions.sv
`timescale 1ns/10ps

module decoder_assertions (
    input logic                               clk,
    input logic [soc_bus_pkg::ADDR_WIDTH-1:0] address,
    input logic [soc_bus_pkg::DATA_WIDTH-1:0] read_data,
    input logic [7:0]                         strobes
);

    logic in_map;

    // Union of the four inclusive ranges of the default address map.
    assign in_map =
        ((address >= soc_bus_pkg::DEVICE0_START) && (address <= soc_bus_pkg::DEVICE0_FINAL)) ||
        ((address >= soc_bus_pkg::DEVICE1_START) && (address <= soc_bus_pkg::DEVICE1_FINAL)) ||
        ((address >= soc_bus_pkg::DEVICE2_START) && (address <= soc_bus_pkg::DEVICE2_FINAL)) ||
        ((address >= soc_bus_pkg::DEVICE3_START) && (address <= soc_bus_pkg::DEVICE3_FINAL));

    one_strobe: assert property (@(posedge clk) $onehot0(strobes))
        else $error("more than one device strobe is high");

    unmapped_no_strobe: assert property (@(posedge clk) !in_map |-> (strobes == '0))
        else $error("a device strobe is high for unmapped address %h", address);

    unmapped_reads_zero: assert property (@(posedge clk) !in_map |-> (read_data == '0))
        else $error("unmapped address %h returns nonzero read data", address);

endmodule

bind bus_decoder decoder_assertions u_decoder_assertions (
    .clk       (soc_bus_top.clk),
    .address   (address),
    .read_data (read_data),
    .strobes   ({dev3.read, dev3.write, dev2.read, dev2.write,
                 dev1.read, dev1.write, dev0.read, dev0.write})
);

//--- tb_soc_bus.sv
`timescale 1ns/10ps

module tb_soc_bus;

    localparam int DW = soc_bus_pkg::DATA_WIDTH;
    localparam int AW = soc_bus_pkg::ADDR_WIDTH;
    localparam int GW = soc_bus_pkg::GPIO_WIDTH;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_OPS = 128;

    logic          clk;
    logic          reset;
    logic          read;
    logic          write;
    logic [AW-1:0] address;
    logic [DW-1:0] write_data;
    logic [DW-1:0] read_data;
    logic [GW-1:0] gpio_in;
    logic [GW-1:0] gpio_out;
    logic          timer_irq;

    // One row per operation line of the cases file.
    int            op_test [MAX_OPS];
    int            op_code [MAX_OPS];
    logic [AW-1:0] op_addr [MAX_OPS];
    logic [DW-1:0] op_data [MAX_OPS];
    logic [DW-1:0] op_expect [MAX_OPS];
    int            op_count = 0;

    // Random words written so far, keyed by address.
    logic [DW-1:0] written [logic [AW-1:0]];

    int cycles = 0;
    int cycle_limit = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int checks = 0;

    soc_bus_top uut (
        .clk        (clk),
        .reset      (reset),
        .read       (read),
        .write      (write),
        .address    (address),
        .write_data (write_data),
        .read_data  (read_data),
        .gpio_in    (gpio_in),
        .gpio_out   (gpio_out),
        .timer_irq  (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the cases did not finish within %0d clock cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic load_cases();
        int            fd;
        int            n;
        int            t;
        int            c;
        logic [AW-1:0] a;
        logic [DW-1:0] d;
        logic [DW-1:0] e;
        string         line;
        fd = $fopen("soc_bus_cases.txt", "r");
        if (fd == 0) begin
            $display("Error: the cases file soc_bus_cases.txt could not be opened");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines do not scan as five fields.
            n = $sscanf(line, "%d %d %h %h %h", t, c, a, d, e);
            if (n == 5 && op_count < MAX_OPS) begin
                op_test[op_count] = t;
                op_code[op_count] = c;
                op_addr[op_count] = a;
                op_data[op_count] = d;
                op_expect[op_count] = e;
                op_count++;
            end
        end
        $fclose(fd);
    endtask

    function automatic int case_cycles();
        int total;
        int i;
        total = 0;
        for (i = 0; i < op_count; i++) begin
            if (op_code[i] == 3) begin
                total += int'(op_data[i]);
            end else if (op_code[i] != 2) begin
                total += 1;
            end
        end
        return total;
    endfunction

    // Each bus access drives on a falling edge and lasts one clock cycle.
    task automatic bus_write(input logic [AW-1:0] a, input logic [DW-1:0] d);
        address = a;
        write_data = d;
        write = 1'b1;
        @(posedge clk);
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic bus_read(input logic [AW-1:0] a, output logic [DW-1:0] d);
        address = a;
        read = 1'b1;
        @(posedge clk);
        d = read_data;
        @(negedge clk);
        read = 1'b0;
    endtask

    task automatic wait_cycles(input logic [DW-1:0] n);
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
        end
    endtask

    task automatic sample_pin(input bit irq_pin, output logic [DW-1:0] value);
        @(posedge clk);
        if (irq_pin) begin
            value = {{(DW - 1){1'b0}}, timer_irq};
        end else begin
            value = {{(DW - GW){1'b0}}, gpio_out};
        end
        @(negedge clk);
    endtask

    task automatic check_value(input string what, input logic [AW-1:0] a,
                               input logic [DW-1:0] expected, input logic [DW-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail at %0d ns: %s, address %h, expected %h, actual %h",
                     $time, what, a, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_test(input int number);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: ok", number);
        end else begin
            $display("test %0d: %0d check(s) failed", number, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic run_op(input int i);
        logic [DW-1:0] got;
        logic [DW-1:0] word;
        case (op_code[i])
            0: bus_write(op_addr[i], op_data[i]);
            1: begin
                bus_read(op_addr[i], got);
                check_value("read", op_addr[i], op_expect[i], got);
            end
            2: gpio_in = op_data[i][GW-1:0];
            3: wait_cycles(op_data[i]);
            4: begin
                sample_pin(1'b1, got);
                check_value("timer_irq", '0, op_expect[i], got);
            end
            5: begin
                sample_pin(1'b0, got);
                check_value("gpio_out", '0, op_expect[i], got);
            end
            6: begin
                word = $urandom();
                written[op_addr[i]] = word;
                bus_write(op_addr[i], word);
            end
            7: begin
                bus_read(op_addr[i], got);
                if (written.exists(op_addr[i])) begin
                    check_value("random readback", op_addr[i], written[op_addr[i]], got);
                end else begin
                    $display("Error: address %h is read back before any random write", op_addr[i]);
                    test_errors++;
                end
            end
            default: begin
                $display("Error: case %0d has the unknown opcode %0d", i, op_code[i]);
                test_errors++;
            end
        endcase
    endtask

    initial begin
        int i;
        int current;
        void'($urandom(94130));
        reset = 1'b1;
        read = 1'b0;
        write = 1'b0;
        address = '0;
        write_data = '0;
        gpio_in = '0;
        load_cases();
        if (op_count == 0) begin
            $display("Error: no cases were read, so nothing was tested");
            errors++;
        end
        cycle_limit = 2 * case_cycles() + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        current = -1;
        for (i = 0; i < op_count; i++) begin
            if (op_test[i] != current) begin
                if (current >= 0) begin
                    report_test(current);
                end
                current = op_test[i];
            end
            run_op(i);
        end
        if (current >= 0) begin
            report_test(current);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- soc_bus_cases.txt
# test op address data expect, all but test and op in hex
# op: 0 write, 1 read and check, 2 set gpio_in, 3 idle data cycles, 4 check timer_irq, 5 check gpio_out, 6 write random word, 7 read back random word
1 6 00000000 00000000 00000000
1 6 00000FFF 00000000 00000000
1 6 000010B9 00000000 00000000
1 6 000013BA 00000000 00000000
1 7 00000000 00000000 00000000
1 7 00000FFF 00000000 00000000
1 7 000010B9 00000000 00000000
1 7 000013BA 00000000 00000000
2 0 00000FFF AAAA5555 00000000
2 0 00001000 0000003C 00000000
2 0 000013BA 12345678 00000000
2 0 000013BB 00000077 00000000
2 1 00000FFF 00000000 AAAA5555
2 1 00001000 00000000 0000003C
2 1 000013BA 00000000 12345678
2 1 000013BB 00000000 00000077
2 0 00001003 DEADBEEF 00000000
2 0 00002000 CAFEF00D 00000000
2 1 00001003 00000000 00000000
2 1 00002000 00000000 00000000
2 7 00000000 00000000 00000000
2 1 00001000 00000000 0000003C
3 0 00001000 000000A5 00000000
3 5 00000000 00000000 000000A5
3 1 00001000 00000000 000000A5
3 0 00001002 0000000F 00000000
3 5 00000000 00000000 000000AA
3 1 00001002 00000000 00000000
4 2 00000000 0000005A 00000000
4 3 00000000 00000001 00000000
4 1 00001001 00000000 0000005A
5 0 000013BB 00000000 00000000
5 0 000013BC 00000005 00000000
5 0 000013BD 00000005 00000000
5 3 00000000 00000007 00000000
5 1 000013BE 00000000 00000001
5 4 00000000 00000000 00000001
5 0 000013BE 00000001 00000000
5 3 00000000 00000001 00000000
5 1 000013BE 00000000 00000000
5 4 00000000 00000000 00000000
6 0 000013BD 00000000 00000000
6 0 000013BE 00000001 00000000
6 0 000013BB 00000000 00000000
6 0 000013BC 00000003 00000000
6 0 000013BD 00000003 00000000
6 3 00000000 00000004 00000000
6 1 000013BE 00000000 00000001
6 1 000013BB 00000000 00000001
6 0 000013BD 00000000 00000000
6 1 000013BB 00000000 00000003
6 4 00000000 00000000 00000000

//--- src.f
soc_bus_pkg.sv
bus_port_if.sv
bus_decoder.sv
word_memory.sv
gpio_registers.sv
interval_timer.sv
soc_bus_top.sv
soc_bus_assertions.sv
tb_soc_bus.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP      = tb_soc_bus
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
